/* filelist.f */
+incdir+.
rob_pkg.sv
rob_cb.sv
rob_dispatch.sv
rob_core.sv
rob_retire.sv
rob_top.sv
rob_sva.sv
rob_tb.sv

/* rob_cb.sv */
`include "rob_config.svh"

module rob_cb #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = `ROB_SZ,
	localparam int IDX_W = $clog2(DEPTH)
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [1:0]       wr_en,
	input  payload_t         wr_data [2],
	input  logic [1:0]       rd_cnt,
	input  logic             rewind,
	input  logic [IDX_W-1:0] rewind_idx,
	output payload_t         rd_data [2],
	output logic [IDX_W-1:0] head,
	output logic [IDX_W-1:0] tail
);

	payload_t mem [DEPTH];

	logic [IDX_W-1:0] head_p1;
	logic [IDX_W-1:0] tail_p1;
	logic [1:0]       wr_cnt;

	assign head_p1 = head + 1'b1;
	assign tail_p1 = tail + 1'b1;

	// slot 1 only ever writes together with slot 0
	assign wr_cnt = {1'b0, wr_en[0]} + {1'b0, wr_en[1]};

	// ========================================
	// storage
	// ========================================

	always_ff @(posedge clk) begin
		if (!rewind) begin
			if (wr_en[0])
				mem[tail] <= wr_data[0];
			if (wr_en[1])
				mem[tail_p1] <= wr_data[1];
		end
	end

	// oldest two entries, visible without a clock
	assign rd_data[0] = mem[head];
	assign rd_data[1] = mem[head_p1];

	// ========================================
	// pointers
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			head <= head + IDX_W'(rd_cnt);
			// rewind drops everything younger than rewind_idx
			if (rewind)
				tail <= rewind_idx;
			else
				tail <= tail + IDX_W'(wr_cnt);
		end
	end

endmodule

/* rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// ========================================
// reorder buffer sizing
// ========================================

// number of entries, kept a power of two so indices wrap
`define ROB_SZ 16
`define ROB_IDX 4

// physical register index width
`define PRF_IDX 6

// pc and branch target width
`define ADDR_W 64

`endif

/* rob_core.sv */
`include "rob_config.svh"

module rob_core (
	input  logic                  clk,
	input  logic                  reset,
	input  rob_pkg::disp_pkt_t    staged [2],
	input  rob_pkg::complete_t    complete [2],
	output rob_pkg::alloc_resp_t  alloc_resp [2],
	output rob_pkg::retire_slot_t retire_slot [2],
	output rob_pkg::redirect_t    redirect,
	output logic [1:0]            credit_ret,
	output logic                  flush
);

	rob_pkg::entry_info_t info_wr [2];
	rob_pkg::entry_info_t info_rd [2];
	rob_pkg::pred_info_t  pred_wr [2];
	rob_pkg::pred_info_t  pred_rd [2];

	logic [`ROB_IDX-1:0] head;
	logic [`ROB_IDX-1:0] tail;
	logic [`ROB_IDX-1:0] head_p1;
	logic [`ROB_IDX-1:0] tail_p1;
	logic [`ROB_IDX-1:0] new_head;
	logic [`ROB_IDX:0]   occ;

	// per-entry execution results
	logic [`ROB_SZ-1:0] rdy;
	logic [`ROB_SZ-1:0] act_taken;
	logic [`ADDR_W-1:0] act_target [`ROB_SZ];

	logic [1:0] alloc_en;
	logic [1:0] alloc_cnt;
	logic [1:0] ret_cnt;
	logic       retire1;
	logic       retire2;
	logic       miss1;
	logic       miss2;

	assign head_p1 = head + 1'b1;
	assign tail_p1 = tail + 1'b1;

	// ========================================
	// allocation
	// ========================================

	assign alloc_en[0] = staged[0].valid && !flush;
	assign alloc_en[1] = staged[1].valid && staged[0].valid && !flush;
	assign alloc_cnt   = {1'b0, alloc_en[0]} + {1'b0, alloc_en[1]};

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			info_wr[i].ir          = staged[i].ir;
			info_wr[i].npc         = staged[i].npc;
			info_wr[i].pdest       = staged[i].pdest;
			info_wr[i].adest       = staged[i].adest;
			pred_wr[i].is_branch   = staged[i].is_branch;
			pred_wr[i].pred_taken  = staged[i].pred_taken;
			pred_wr[i].pred_target = staged[i].pred_target;
		end
		alloc_resp[0].valid = alloc_en[0];
		alloc_resp[0].idx   = tail;
		alloc_resp[1].valid = alloc_en[1];
		alloc_resp[1].idx   = tail_p1;
	end

	// ========================================
	// retire decision
	// ========================================

	assign retire1 = occ != '0 && rdy[head];
	assign retire2 = occ > (`ROB_IDX+1)'(1) && retire1 && rdy[head_p1];

	// direction or target wrong
	assign miss1 = retire1 && pred_rd[0].is_branch &&
		(act_taken[head] != pred_rd[0].pred_taken ||
		act_target[head] != pred_rd[0].pred_target);
	assign miss2 = retire2 && !miss1 && pred_rd[1].is_branch &&
		(act_taken[head_p1] != pred_rd[1].pred_taken ||
		act_target[head_p1] != pred_rd[1].pred_target);

	assign ret_cnt    = miss1 ? 2'd1 : {1'b0, retire1} + {1'b0, retire2};
	assign credit_ret = ret_cnt;
	assign flush      = miss1 || miss2;
	// squash leaves the buffer empty at the new head
	assign new_head   = head + `ROB_IDX'(ret_cnt);

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			retire_slot[i].adest = info_rd[i].adest;
			retire_slot[i].pdest = info_rd[i].pdest;
			retire_slot[i].npc   = info_rd[i].npc;
		end
		retire_slot[0].valid = retire1;
		retire_slot[1].valid = retire2 && !miss1;
		redirect.valid       = flush;
		redirect.target      = miss2 ? act_target[head_p1] : act_target[head];
	end

	// ========================================
	// entry state
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			rdy <= '0;
		end else begin
			if (alloc_en[0])
				rdy[tail] <= 1'b0;
			if (alloc_en[1])
				rdy[tail_p1] <= 1'b0;
			// completion slot 1 is honoured only with slot 0
			if (complete[0].valid) begin
				rdy[complete[0].rob_idx] <= 1'b1;
				if (complete[1].valid)
					rdy[complete[1].rob_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_en[0]) begin
			act_taken[tail]  <= 1'b0;
			act_target[tail] <= '0;
		end
		if (alloc_en[1]) begin
			act_taken[tail_p1]  <= 1'b0;
			act_target[tail_p1] <= '0;
		end
		if (complete[0].valid) begin
			act_taken[complete[0].rob_idx]  <= complete[0].actual_taken;
			act_target[complete[0].rob_idx] <= complete[0].actual_target;
			if (complete[1].valid) begin
				act_taken[complete[1].rob_idx]  <= complete[1].actual_taken;
				act_target[complete[1].rob_idx] <= complete[1].actual_target;
			end
		end
	end

	// occupancy, head == tail alone is ambiguous when full
	always_ff @(posedge clk) begin
		if (reset || flush)
			occ <= '0;
		else
			occ <= occ + (`ROB_IDX+1)'(alloc_cnt) - (`ROB_IDX+1)'(ret_cnt);
	end

	rob_cb #(.payload_t(rob_pkg::entry_info_t), .DEPTH(`ROB_SZ)) u_info (
		.clk        (clk),
		.reset      (reset),
		.wr_en      (alloc_en),
		.wr_data    (info_wr),
		.rd_cnt     (ret_cnt),
		.rewind     (flush),
		.rewind_idx (new_head),
		.rd_data    (info_rd),
		.head       (head),
		.tail       (tail)
	);

	rob_cb #(.payload_t(rob_pkg::pred_info_t), .DEPTH(`ROB_SZ)) u_pred (
		.clk        (clk),
		.reset      (reset),
		.wr_en      (alloc_en),
		.wr_data    (pred_wr),
		.rd_cnt     (ret_cnt),
		.rewind     (flush),
		.rewind_idx (new_head),
		.rd_data    (pred_rd),
		.head       (),
		.tail       ()
	);

endmodule

/* rob_dispatch.sv */
`include "rob_config.svh"

module rob_dispatch (
	input  logic               clk,
	input  logic               reset,
	input  rob_pkg::disp_pkt_t disp_in [2],
	input  logic [1:0]         credit_ret,
	input  logic               flush,
	output logic [1:0]         disp_accept,
	output rob_pkg::disp_pkt_t staged [2]
);

	// free entries not yet promised to a packet
	logic [`ROB_IDX:0] credits;
	logic [1:0]        valid_cnt;

	// ========================================
	// accept count
	// ========================================

	// in order: slot 1 counts only behind a valid slot 0
	always_comb begin
		if (!disp_in[0].valid)
			valid_cnt = 2'd0;
		else if (!disp_in[1].valid)
			valid_cnt = 2'd1;
		else
			valid_cnt = 2'd2;
	end

	always_comb begin
		disp_accept = valid_cnt;
		if (credits < (`ROB_IDX+1)'(disp_accept))
			disp_accept = credits[1:0];
		// squash cycle, staging is about to be dropped
		if (flush)
			disp_accept = 2'd0;
	end

	// ========================================
	// credits and staging
	// ========================================

	always_ff @(posedge clk) begin
		if (reset || flush)
			credits <= (`ROB_IDX+1)'(`ROB_SZ);
		else
			credits <= credits + (`ROB_IDX+1)'(credit_ret) - (`ROB_IDX+1)'(disp_accept);
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			staged[0].valid <= 1'b0;
			staged[1].valid <= 1'b0;
		end else begin
			staged[0]       <= disp_in[0];
			staged[1]       <= disp_in[1];
			staged[0].valid <= disp_accept != 2'd0;
			staged[1].valid <= disp_accept == 2'd2;
		end
	end

endmodule

/* rob_pkg.sv */
`include "rob_config.svh"

package rob_pkg;

	// ========================================
	// dispatch side
	// ========================================

	// one decoded instruction from the front end
	typedef struct packed {
		logic                valid;
		logic [31:0]         ir;
		logic [`ADDR_W-1:0]  npc;
		logic [`PRF_IDX-1:0] pdest;
		logic [4:0]          adest;
		logic                is_branch;
		logic                pred_taken;
		logic [`ADDR_W-1:0]  pred_target;
	} disp_pkt_t;

	// static part of an entry, never touched after allocation
	typedef struct packed {
		logic [31:0]         ir;
		logic [`ADDR_W-1:0]  npc;
		logic [`PRF_IDX-1:0] pdest;
		logic [4:0]          adest;
	} entry_info_t;

	// prediction made at fetch
	typedef struct packed {
		logic               is_branch;
		logic               pred_taken;
		logic [`ADDR_W-1:0] pred_target;
	} pred_info_t;

	typedef struct packed {
		logic                valid;
		logic [`ROB_IDX-1:0] idx;
	} alloc_resp_t;

	// ========================================
	// execution and retire side
	// ========================================

	typedef struct packed {
		logic                valid;
		logic [`ROB_IDX-1:0] rob_idx;
		logic                actual_taken;
		logic [`ADDR_W-1:0]  actual_target;
	} complete_t;

	typedef struct packed {
		logic                valid;
		logic [4:0]          adest;
		logic [`PRF_IDX-1:0] pdest;
		logic [`ADDR_W-1:0]  npc;
	} retire_slot_t;

	typedef struct packed {
		logic                valid;
		logic [4:0]          adest;
		logic [`PRF_IDX-1:0] pdest;
		logic [`ADDR_W-1:0]  npc;
		logic [`PRF_IDX-1:0] freed_pdest;
	} commit_t;

	typedef struct packed {
		logic               valid;
		logic [`ADDR_W-1:0] target;
	} redirect_t;

endpackage

/* rob_retire.sv */
`include "rob_config.svh"

module rob_retire (
	input  logic                  clk,
	input  logic                  reset,
	input  rob_pkg::retire_slot_t retire_slot [2],
	input  rob_pkg::redirect_t    redirect_in,
	output rob_pkg::commit_t      commit [2],
	output rob_pkg::redirect_t    redirect
);

	// architectural register to physical register
	logic [`PRF_IDX-1:0] arch_map [32];
	logic [`PRF_IDX-1:0] freed [2];

	// slot 1 sees slot 0's write to the same register
	assign freed[0] = arch_map[retire_slot[0].adest];
	assign freed[1] = (retire_slot[0].valid && retire_slot[1].adest == retire_slot[0].adest) ?
		retire_slot[0].pdest : arch_map[retire_slot[1].adest];

	// ========================================
	// map table
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				arch_map[i] <= `PRF_IDX'(i);
		end else begin
			if (retire_slot[0].valid)
				arch_map[retire_slot[0].adest] <= retire_slot[0].pdest;
			// younger write lands last
			if (retire_slot[1].valid)
				arch_map[retire_slot[1].adest] <= retire_slot[1].pdest;
		end
	end

	// ========================================
	// output registers
	// ========================================

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			commit[i].adest       <= retire_slot[i].adest;
			commit[i].pdest       <= retire_slot[i].pdest;
			commit[i].npc         <= retire_slot[i].npc;
			commit[i].freed_pdest <= freed[i];
		end
		redirect.target <= redirect_in.target;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			commit[0].valid <= 1'b0;
			commit[1].valid <= 1'b0;
			redirect.valid  <= 1'b0;
		end else begin
			commit[0].valid <= retire_slot[0].valid;
			commit[1].valid <= retire_slot[1].valid;
			redirect.valid  <= redirect_in.valid;
		end
	end

endmodule

/* rob_sva.sv */
module rob_sva (
	input logic                 clk,
	input logic                 reset,
	input rob_pkg::disp_pkt_t   disp_in [2],
	input logic [1:0]           disp_accept,
	input rob_pkg::alloc_resp_t alloc_resp [2],
	input rob_pkg::commit_t     commit [2],
	input rob_pkg::redirect_t   redirect
);

	int fail_cnt = 0;

	// valid slots counted in order
	logic [1:0] in_cnt;

	assign in_cnt = !disp_in[0].valid ? 2'd0 : (disp_in[1].valid ? 2'd2 : 2'd1);

	// ========================================
	// protocol
	// ========================================

	a_commit_order: assert property (@(posedge clk) disable iff (reset)
		commit[1].valid |-> commit[0].valid)
	else begin
		fail_cnt++;
		$error("commit slot 2 valid without slot 1");
	end

	a_accept_bound: assert property (@(posedge clk) disable iff (reset)
		disp_accept <= in_cnt)
	else begin
		fail_cnt++;
		$error("disp_accept above the number of valid input slots");
	end

	// first cycle out of reset
	a_reset_quiet: assert property (@(posedge clk)
		$fell(reset) |-> !(commit[0].valid || commit[1].valid || redirect.valid ||
		alloc_resp[0].valid || alloc_resp[1].valid))
	else begin
		fail_cnt++;
		$error("output valid in the first cycle after reset");
	end

endmodule

bind rob_top rob_sva i_sva (.*);

/* rob_tb.sv */
`include "rob_config.svh"

module rob_tb;

	// several times the length of all tests together
	localparam int MAX_CYCLES = 2000;

	typedef struct packed {
		rob_pkg::disp_pkt_t  pkt;
		logic [`ROB_IDX-1:0] idx;
	} sb_entry_t;

	logic                  clk;
	logic                  reset;
	rob_pkg::disp_pkt_t    disp_in [2];
	logic [1:0]            disp_accept;
	rob_pkg::alloc_resp_t  alloc_resp [2];
	rob_pkg::complete_t    complete [2];
	rob_pkg::commit_t      commit [2];
	rob_pkg::redirect_t    redirect;

	integer seed = 19;
	int     cycle_cnt;

	// packets waiting to be offered, accepted but not allocated, in flight
	rob_pkg::disp_pkt_t tx_q [$];
	rob_pkg::disp_pkt_t pend_q [$];
	sb_entry_t          sb_q [$];

	// reference state
	logic [`PRF_IDX-1:0] arch_model [32];
	int                  credit_model;
	logic [`ROB_IDX-1:0] head_model;
	logic [`ROB_IDX-1:0] tail_model;
	int                  redirect_cnt;
	int                  same_pair_cnt;

	// prediction per entry and the outcome the test will report
	logic               pred_br [`ROB_SZ];
	logic               pred_tk [`ROB_SZ];
	logic [`ADDR_W-1:0] pred_tg [`ROB_SZ];
	logic               out_tk [`ROB_SZ];
	logic [`ADDR_W-1:0] out_tg [`ROB_SZ];

	rob_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.disp_in     (disp_in),
		.disp_accept (disp_accept),
		.alloc_resp  (alloc_resp),
		.complete    (complete),
		.commit      (commit),
		.redirect    (redirect)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("** Error: time %0t, run did not finish within %0d cycles", $time, MAX_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	// ========================================
	// checking helpers
	// ========================================

	task automatic abort_run;
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_equal(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		assert (exp === act)
		else begin
			$display("** Error: time %0t, %s expected %0h, actual %0h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic expect_true(input logic cond, input string msg);
		assert (cond)
		else begin
			$display("** Error: time %0t, %s", $time, msg);
			abort_run();
		end
	endtask

	// one commit slot against the oldest outstanding instruction
	task automatic retire_one(input int s, output logic miss, output logic [`ADDR_W-1:0] tgt);
		sb_entry_t        e;
		rob_pkg::commit_t c;
		c = commit[s];
		expect_true(sb_q.size() != 0, "commit with no outstanding instruction");
		e = sb_q.pop_front();
		expect_equal($sformatf("commit[%0d].adest", s), e.pkt.adest, c.adest);
		expect_equal($sformatf("commit[%0d].pdest", s), e.pkt.pdest, c.pdest);
		expect_equal($sformatf("commit[%0d].npc", s), e.pkt.npc, c.npc);
		expect_equal($sformatf("commit[%0d].freed_pdest", s), arch_model[e.pkt.adest],
			c.freed_pdest);
		// slot 1 sees slot 0's update through the sequential model
		arch_model[e.pkt.adest] = e.pkt.pdest;
		head_model++;
		miss = pred_br[e.idx] && (out_tk[e.idx] != pred_tk[e.idx] ||
			out_tg[e.idx] != pred_tg[e.idx]);
		tgt = out_tg[e.idx];
	endtask

	task automatic watch_outputs;
		logic               miss;
		logic               squash;
		logic [`ADDR_W-1:0] tgt;
		int                 n_ret;
		int                 exp_acc;
		sb_entry_t          e;
		squash = 1'b0;
		n_ret = 0;
		tgt = '0;
		if (commit[0].valid) begin
			retire_one(0, miss, tgt);
			n_ret++;
			if (miss) begin
				squash = 1'b1;
				expect_true(!commit[1].valid, "commit beside a mispredicted slot 1 branch");
			end
		end
		if (commit[1].valid && !squash) begin
			retire_one(1, miss, tgt);
			n_ret++;
			squash = miss;
		end
		if (commit[0].valid && commit[1].valid && commit[0].adest == commit[1].adest)
			same_pair_cnt++;
		if (squash) begin
			expect_true(redirect.valid, "mispredicted branch committed without redirect");
			expect_equal("redirect.target", tgt, redirect.target);
			// every younger entry is gone and its credit is back
			sb_q.delete();
			credit_model = `ROB_SZ;
			tail_model = head_model;
			redirect_cnt++;
		end else begin
			expect_true(!redirect.valid, "redirect without a mispredicted branch");
			credit_model += n_ret;
		end

		for (int s = 0; s < 2; s++) begin
			if (alloc_resp[s].valid) begin
				expect_true(pend_q.size() != 0, "allocation with no accepted instruction");
				e.pkt = pend_q.pop_front();
				e.idx = tail_model;
				expect_equal($sformatf("alloc_resp[%0d].idx", s), tail_model,
					alloc_resp[s].idx);
				sb_q.push_back(e);
				pred_br[e.idx] = e.pkt.is_branch;
				pred_tk[e.idx] = e.pkt.pred_taken;
				pred_tg[e.idx] = e.pkt.pred_target;
				// correct prediction unless a test says otherwise
				out_tk[e.idx] = e.pkt.pred_taken;
				out_tg[e.idx] = e.pkt.pred_target;
				tail_model++;
			end
		end

		// in-order valid count limited by credits and width
		exp_acc = !disp_in[0].valid ? 0 : (disp_in[1].valid ? 2 : 1);
		if (credit_model < exp_acc)
			exp_acc = credit_model;
		expect_equal("disp_accept", exp_acc, disp_accept);
		if (disp_accept != 2'd0)
			pend_q.push_back(disp_in[0]);
		if (disp_accept == 2'd2)
			pend_q.push_back(disp_in[1]);
		credit_model -= disp_accept;
	endtask

	always @(negedge clk) begin
		if (!reset)
			watch_outputs();
	end

	// ========================================
	// stimulus helpers
	// ========================================

	function automatic rob_pkg::disp_pkt_t make_pkt(input logic [4:0] adest, input logic br,
			input logic tk, input logic [`ADDR_W-1:0] tgt);
		rob_pkg::disp_pkt_t p;
		p.valid       = 1'b1;
		p.ir          = $random(seed);
		p.npc         = {32'h0, $random(seed)};
		p.pdest       = `PRF_IDX'($random(seed));
		p.adest       = adest;
		p.is_branch   = br;
		p.pred_taken  = tk;
		p.pred_target = tgt;
		return p;
	endfunction

	task automatic queue_plain(input int n);
		for (int k = 0; k < n; k++)
			tx_q.push_back(make_pkt(5'($random(seed)), 1'b0, 1'b0, '0));
	endtask

	// offers the head of tx_q until it is empty or the cycles run out
	task automatic dispatch_queued(input int max_cycles, output int accepted);
		int cyc;
		accepted = 0;
		cyc = 0;
		while (tx_q.size() != 0 && cyc < max_cycles) begin
			@(posedge clk);
			disp_in[0] <= tx_q[0];
			disp_in[1] <= (tx_q.size() > 1) ? tx_q[1] : '0;
			@(negedge clk);
			for (int k = 0; k < disp_accept; k++)
				void'(tx_q.pop_front());
			accepted += disp_accept;
			cyc++;
		end
		@(posedge clk);
		disp_in[0] <= '0;
		disp_in[1] <= '0;
	endtask

	task automatic complete_pair(input int a, input int b);
		rob_pkg::complete_t c0;
		rob_pkg::complete_t c1;
		c0.valid         = 1'b1;
		c0.rob_idx       = a[`ROB_IDX-1:0];
		c0.actual_taken  = out_tk[a];
		c0.actual_target = out_tg[a];
		c1 = '0;
		if (b >= 0) begin
			c1.valid         = 1'b1;
			c1.rob_idx       = b[`ROB_IDX-1:0];
			c1.actual_taken  = out_tk[b];
			c1.actual_target = out_tg[b];
		end
		@(posedge clk);
		complete[0] <= c0;
		complete[1] <= c1;
		@(posedge clk);
		complete[0] <= '0;
		complete[1] <= '0;
	endtask

	task automatic wait_alloc;
		while (pend_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic wait_drain;
		while (sb_q.size() != 0)
			@(posedge clk);
	endtask

	// waits for a redirect and watches a few cycles for stray commits
	task automatic wait_redirect(input int base);
		while (redirect_cnt == base)
			@(posedge clk);
		repeat (8) @(posedge clk);
		expect_equal("redirect count", base + 1, redirect_cnt);
	endtask

	task automatic complete_all_in_order;
		int ids [$];
		for (int k = 0; k < sb_q.size(); k++)
			ids.push_back(sb_q[k].idx);
		for (int k = 0; k < ids.size(); k += 2) begin
			if (k + 1 < ids.size())
				complete_pair(ids[k], ids[k + 1]);
			else
				complete_pair(ids[k], -1);
		end
	endtask

	// ========================================
	// directed tests
	// ========================================

	task automatic credit_limit;
		int acc;
		queue_plain(40);
		dispatch_queued(12, acc);
		tx_q.delete();
		expect_equal("accepted total", `ROB_SZ, acc);
		wait_alloc();
	endtask

	task automatic in_order_retire;
		int ids [$];
		int j;
		int t;
		int acc;
		for (int k = 0; k < sb_q.size(); k++)
			ids.push_back(sb_q[k].idx);
		// shuffle completion order
		for (int k = ids.size() - 1; k > 0; k--) begin
			j = $unsigned($random(seed)) % (k + 1);
			t = ids[k];
			ids[k] = ids[j];
			ids[j] = t;
		end
		for (int k = 0; k < ids.size(); k += 2)
			complete_pair(ids[k], ids[k + 1]);
		wait_drain();
		queue_plain(4);
		dispatch_queued(10, acc);
		expect_equal("accepted after retirement", 4, acc);
		wait_alloc();
		complete_all_in_order();
		wait_drain();
	endtask

	task automatic freed_registers;
		int acc;
		for (int k = 0; k < 4; k++) begin
			tx_q.push_back(make_pkt(5'(k + 1), 1'b0, 1'b0, '0));
			tx_q.push_back(make_pkt(5'(k + 1), 1'b0, 1'b0, '0));
		end
		same_pair_cnt = 0;
		dispatch_queued(10, acc);
		expect_equal("accepted pairs", 8, acc);
		wait_alloc();
		complete_all_in_order();
		wait_drain();
		expect_equal("same adest pair commits", 4, same_pair_cnt);
	endtask

	task automatic mispredict_first_slot;
		int ids [$];
		int acc;
		int base;
		base = redirect_cnt;
		tx_q.push_back(make_pkt(5'($random(seed)), 1'b0, 1'b0, '0));
		tx_q.push_back(make_pkt(5'($random(seed)), 1'b1, 1'b1, 64'h1000));
		queue_plain(4);
		dispatch_queued(10, acc);
		expect_equal("accepted burst", 6, acc);
		wait_alloc();
		for (int k = 0; k < sb_q.size(); k++)
			ids.push_back(sb_q[k].idx);
		// right direction, wrong target
		out_tg[ids[1]] = 64'h2040;
		complete_pair(ids[0], -1);
		complete_pair(ids[2], ids[3]);
		complete_pair(ids[4], ids[5]);
		complete_pair(ids[1], -1);
		wait_redirect(base);
		queue_plain(40);
		dispatch_queued(14, acc);
		tx_q.delete();
		expect_equal("accepted after squash", `ROB_SZ, acc);
		wait_alloc();
		complete_all_in_order();
		wait_drain();
	endtask

	task automatic mispredict_second_slot;
		int ids [$];
		int acc;
		int base;
		base = redirect_cnt;
		tx_q.push_back(make_pkt(5'($random(seed)), 1'b0, 1'b0, '0));
		tx_q.push_back(make_pkt(5'($random(seed)), 1'b1, 1'b0, 64'h3000));
		queue_plain(2);
		dispatch_queued(10, acc);
		expect_equal("accepted burst", 4, acc);
		wait_alloc();
		for (int k = 0; k < sb_q.size(); k++)
			ids.push_back(sb_q[k].idx);
		// predicted not taken but resolves taken
		out_tk[ids[1]] = 1'b1;
		complete_pair(ids[2], ids[3]);
		complete_pair(ids[0], ids[1]);
		wait_redirect(base);

		// branches that resolve as predicted
		tx_q.push_back(make_pkt(5'($random(seed)), 1'b1, 1'b1, 64'h4000));
		tx_q.push_back(make_pkt(5'($random(seed)), 1'b1, 1'b0, 64'h4800));
		queue_plain(1);
		dispatch_queued(10, acc);
		expect_equal("accepted burst", 3, acc);
		wait_alloc();
		complete_all_in_order();
		wait_drain();
		repeat (4) @(posedge clk);
		expect_equal("redirect count", base + 1, redirect_cnt);
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		reset = 1'b1;
		disp_in[0] = '0;
		disp_in[1] = '0;
		complete[0] = '0;
		complete[1] = '0;
		for (int i = 0; i < 32; i++)
			arch_model[i] = `PRF_IDX'(i);
		credit_model = `ROB_SZ;
		head_model = '0;
		tail_model = '0;
		redirect_cnt = 0;
		same_pair_cnt = 0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		credit_limit();
		in_order_retire();
		freed_registers();
		mispredict_first_slot();
		mispredict_second_slot();
		repeat (4) @(posedge clk);

		if (i_dut.i_sva.fail_cnt == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("** Error: time %0t, %0d bound assertion failures", $time,
				i_dut.i_sva.fail_cnt);
			$display("Simulation FAILED");
			$fatal(1, "bound assertions failed");
		end
	end

endmodule

/* rob_top.sv */
module rob_top (
	input  logic                 clk,
	input  logic                 reset,
	input  rob_pkg::disp_pkt_t   disp_in [2],
	output logic [1:0]           disp_accept,
	output rob_pkg::alloc_resp_t alloc_resp [2],
	input  rob_pkg::complete_t   complete [2],
	output rob_pkg::commit_t     commit [2],
	output rob_pkg::redirect_t   redirect
);

	rob_pkg::disp_pkt_t    staged [2];
	rob_pkg::retire_slot_t retire_slot [2];
	rob_pkg::redirect_t    core_redirect;
	logic [1:0]            credit_ret;
	logic                  flush;

	// ========================================
	// dispatch, core, retire
	// ========================================

	rob_dispatch i_dispatch (
		.clk         (clk),
		.reset       (reset),
		.disp_in     (disp_in),
		.credit_ret  (credit_ret),
		.flush       (flush),
		.disp_accept (disp_accept),
		.staged      (staged)
	);

	rob_core i_core (
		.clk         (clk),
		.reset       (reset),
		.staged      (staged),
		.complete    (complete),
		.alloc_resp  (alloc_resp),
		.retire_slot (retire_slot),
		.redirect    (core_redirect),
		.credit_ret  (credit_ret),
		.flush       (flush)
	);

	// commit and redirect leave through registers
	rob_retire i_retire (
		.clk         (clk),
		.reset       (reset),
		.retire_slot (retire_slot),
		.redirect_in (core_redirect),
		.commit      (commit),
		.redirect    (redirect)
	);

endmodule
